/* rtl/mxu_prec_pkg.sv */
`default_nettype none

package mxu_prec_pkg;

   // ==============================
   // number formats
   // ==============================
   localparam int LANE_W = 4;  // narrow lane, two per word

   // codes 2'b10 and 2'b11 are illegal
   typedef enum logic [1:0] {
      prec_int8   = 2'b00,  // one signed 8-bit lane
      prec_int4x2 = 2'b01   // two signed 4-bit lanes
   } prec_e;

   // one word, read either as a full lane or as a hi/lo pair
   typedef union packed {
      logic signed [2*LANE_W-1:0] full;
      struct packed {
         logic signed [LANE_W-1:0] hi;
         logic signed [LANE_W-1:0] lo;
      } lanes;
   } mxu_word_u;

   // lane-wise product, each lane truncated to its own width
   function automatic mxu_word_u lane_mul(prec_e prec, mxu_word_u a, mxu_word_u b);
      mxu_word_u r;
      r = '0;
      if (prec == prec_int4x2) begin
         r.lanes.hi = a.lanes.hi * b.lanes.hi;
         r.lanes.lo = a.lanes.lo * b.lanes.lo;  // no carry into hi
      end else begin
         r.full = a.full * b.full;
      end
      return r;
   endfunction

   // lane-wise wrapping sum
   function automatic mxu_word_u lane_add(prec_e prec, mxu_word_u a, mxu_word_u b);
      mxu_word_u r;
      r = '0;
      if (prec == prec_int4x2) begin
         r.lanes.hi = a.lanes.hi + b.lanes.hi;
         r.lanes.lo = a.lanes.lo + b.lanes.lo;
      end else begin
         r.full = a.full + b.full;
      end
      return r;
   endfunction

endpackage

`default_nettype wire

/* rtl/mxu_geom_pkg.sv */
`default_nettype none

package mxu_geom_pkg;

   // ==============================
   // array geometry
   // ==============================

   // every data, weight and result word has this width
   // and must match the width of mxu_prec_pkg::mxu_word_u
   localparam int WORD_W = 8;

   // default grid size, M rows by K columns
   // rows map to weights and outputs, columns to input data
   localparam int DEF_ROWS = 3;
   localparam int DEF_COLS = 3;

endpackage

`default_nettype wire

/* rtl/mxu_mult.sv */
`timescale 1ns/10ps
`default_nettype none

// column-0 cell of the array
// no partial sum comes in here, so the cell only multiplies
module mxu_mult (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    enable,
   input  mxu_prec_pkg::prec_e     select_precision,
   input  mxu_prec_pkg::mxu_word_u data_input,
   input  mxu_prec_pkg::mxu_word_u weight,
   output mxu_prec_pkg::mxu_word_u res_mac_n,
   output mxu_prec_pkg::mxu_word_u data_input_next_row
);

   mxu_prec_pkg::mxu_word_u prod;  // combinational lane product

   assign prod = mxu_prec_pkg::lane_mul(select_precision, data_input, weight);

   // ==============================
   // result and forward registers
   // ==============================
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         res_mac_n           <= '0;
         data_input_next_row <= '0;
      end else if (enable) begin
         res_mac_n           <= prod;
         data_input_next_row <= data_input;  // one row down next cycle
      end
   end

endmodule

`default_nettype wire

/* rtl/mxu_mac.sv */
`timescale 1ns/10ps
`default_nettype none

// inner and last-column cell
// adds its own lane product to the partial sum from the left neighbour
module mxu_mac (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    enable,
   input  logic                    enable_chain,
   input  mxu_prec_pkg::prec_e     select_precision,
   input  mxu_prec_pkg::mxu_word_u data_input,
   input  mxu_prec_pkg::mxu_word_u weight,
   input  mxu_prec_pkg::mxu_word_u res_mac_p,
   output mxu_prec_pkg::mxu_word_u res_mac_n,
   output mxu_prec_pkg::mxu_word_u data_input_next_row
);

   mxu_prec_pkg::mxu_word_u prod;
   mxu_prec_pkg::mxu_word_u sum;
   mxu_prec_pkg::mxu_word_u nxt;

   // ==============================
   // lane arithmetic
   // ==============================
   assign prod = mxu_prec_pkg::lane_mul(select_precision, data_input, weight);
   assign sum  = mxu_prec_pkg::lane_add(select_precision, res_mac_p, prod);

   // chain cut leaves only the local product
   assign nxt = enable_chain ? sum : prod;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         res_mac_n           <= '0;
         data_input_next_row <= '0;
      end else if (enable) begin
         res_mac_n           <= nxt;         // wraps per lane
         data_input_next_row <= data_input;
      end
   end

   // ==============================
   // checks
   // ==============================

   // a frozen array must not move its partial sums
   a_freeze_hold: assert property (
      @(posedge clk) disable iff (!rst_n)
      !enable |=> $stable(res_mac_n)
   ) else $error("mxu_mac: res_mac_n changed while enable was low");

endmodule

`default_nettype wire

/* rtl/mxu_core.sv */
`timescale 1ns/10ps
`default_nettype none

// M x K systolic grid
// data words walk down the columns, partial sums walk right along the rows
module mxu_core #(
   parameter int M = 3,  // rows, one weight and one output word each
   parameter int K = 3   // columns, one input data word each
) (
   input  logic                                clk,
   input  logic                                rst_n,
   input  mxu_prec_pkg::prec_e                 select_precision,
   input  logic                                enable,
   input  logic                                enable_chain,
   input  logic [K*mxu_geom_pkg::WORD_W-1:0]   input_data,
   input  logic [M*mxu_geom_pkg::WORD_W-1:0]   weight,
   output logic [M*mxu_geom_pkg::WORD_W-1:0]   y
);

   localparam int W = mxu_geom_pkg::WORD_W;

   // per-cell outputs
   mxu_prec_pkg::mxu_word_u res_mac_next [M][K];      // partial sums, left to right
   mxu_prec_pkg::mxu_word_u data_in_next_row [M][K];  // forwarded data, top to bottom

   // ==============================
   // grid generation
   // ==============================
   generate
      if (M < 2 || K < 2) begin : g_bad_size
         $error("mxu_core: M and K must both be at least 2");
      end

      for (genvar i = 0; i < M; i++) begin : g_row
         for (genvar j = 0; j < K; j++) begin : g_col
            mxu_prec_pkg::mxu_word_u cell_data;
            mxu_prec_pkg::mxu_word_u cell_weight;

            // row 0 reads the external slice, the rest read the row above
            if (i == 0) begin : g_top
               assign cell_data = input_data[j*W +: W];
            end else begin : g_inner
               assign cell_data = data_in_next_row[i-1][j];
            end

            assign cell_weight = weight[i*W +: W];  // unregistered, shared along row

            if (j == 0) begin : g_mult
               mxu_mult u_mult (
                  .clk                 (clk),
                  .rst_n               (rst_n),
                  .enable              (enable),
                  .select_precision    (select_precision),
                  .data_input          (cell_data),
                  .weight              (cell_weight),
                  .res_mac_n           (res_mac_next[i][j]),
                  .data_input_next_row (data_in_next_row[i][j])
               );
            end else begin : g_mac
               mxu_mac u_mac (
                  .clk                 (clk),
                  .rst_n               (rst_n),
                  .enable              (enable),
                  .enable_chain        (enable_chain),
                  .select_precision    (select_precision),
                  .data_input          (cell_data),
                  .weight              (cell_weight),
                  .res_mac_p           (res_mac_next[i][j-1]),
                  .res_mac_n           (res_mac_next[i][j]),
                  .data_input_next_row (data_in_next_row[i][j])
               );
            end
         end

         // last column of the row is the output word
         assign y[i*W +: W] = res_mac_next[i][K-1];
      end
   endgenerate

endmodule

`default_nettype wire

/* rtl/mxu_top.sv */
`timescale 1ns/10ps
`default_nettype none

// top level of the matrix unit
module mxu_top #(
   parameter int M = mxu_geom_pkg::DEF_ROWS,
   parameter int K = mxu_geom_pkg::DEF_COLS
) (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic [1:0]                          data_type,
   input  logic                                enable,
   input  logic                                enable_chain,
   input  logic [K*mxu_geom_pkg::WORD_W-1:0]   input_data,
   input  logic [M*mxu_geom_pkg::WORD_W-1:0]   weight,
   output logic [M*mxu_geom_pkg::WORD_W-1:0]   y
);

   mxu_prec_pkg::prec_e select_precision;  // registered data_type

   // ==============================
   // precision register
   // ==============================
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         select_precision <= mxu_prec_pkg::prec_int8;
      end else if (enable) begin
         select_precision <= mxu_prec_pkg::prec_e'(data_type);  // frozen with the array
      end
   end

   // only the two defined codes may be driven out of reset
   a_legal_prec: assert property (
      @(posedge clk) disable iff (!rst_n)
      data_type inside {mxu_prec_pkg::prec_int8, mxu_prec_pkg::prec_int4x2}
   ) else $error("mxu_top: illegal data_type %b", data_type);

   mxu_core #(
      .M (M),
      .K (K)
   ) u_core (
      .clk              (clk),
      .rst_n            (rst_n),
      .select_precision (select_precision),
      .enable           (enable),
      .enable_chain     (enable_chain),
      .input_data       (input_data),
      .weight           (weight),
      .y                (y)
   );

endmodule

`default_nettype wire

/* tb/mxu_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

// free-running clock and synchronous reset for the testbench
module mxu_clk_gen #(
   parameter int HALF_PERIOD = 2,  // 4 ns period
   parameter int RST_CYCLES  = 10
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   initial begin
      rst_n <= 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;  // released on a clock edge
   end

endmodule

`default_nettype wire

/* tb/mxu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module mxu_tb;

   localparam int M           = mxu_geom_pkg::DEF_ROWS;
   localparam int K           = mxu_geom_pkg::DEF_COLS;
   localparam int W           = mxu_geom_pkg::WORD_W;
   localparam int VEC_W       = 3 + K + 2*M;  // bytes per line of the data file
   localparam int MAX_TESTS   = 64;
   localparam int RST_TIMEOUT = 100;
   localparam string TESTDATA = "tb/mxu_testdata.txt";

   logic           clk;
   logic           rst_n;
   logic [1:0]     data_type;
   logic           enable;
   logic           enable_chain;
   logic [K*W-1:0] input_data;
   logic [M*W-1:0] weight;
   logic [M*W-1:0] y;

   logic [7:0] vec_mem [0:VEC_W*MAX_TESTS-1];

   mxu_prec_pkg::mxu_word_u last_exp [M];  // last settled y
   mxu_prec_pkg::mxu_word_u next_exp [M];

   int unsigned n_tests;
   int unsigned n_failed;
   int unsigned n_errors;
   int unsigned test_errors;

   mxu_clk_gen u_clk_gen (
      .clk   (clk),
      .rst_n (rst_n)
   );

   mxu_top #(
      .M (M),
      .K (K)
   ) dut (
      .clk          (clk),
      .rst_n        (rst_n),
      .data_type    (data_type),
      .enable       (enable),
      .enable_chain (enable_chain),
      .input_data   (input_data),
      .weight       (weight),
      .y            (y)
   );

   // ==============================
   // reference model
   // ==============================
   function automatic int sign_ext4(input logic [3:0] v);
      return v[3] ? int'(v) - 16 : int'(v);
   endfunction

   function automatic int sign_ext8(input logic [7:0] v);
      return v[7] ? int'(v) - 256 : int'(v);
   endfunction

   // row i sees weight i against every data word, or only the last one when cut
   function automatic mxu_prec_pkg::mxu_word_u model_row(input int base, input int row);
      logic [7:0] w;
      logic [7:0] d;
      int first;
      int acc_full;
      int acc_hi;
      int acc_lo;
      mxu_prec_pkg::mxu_word_u r;
      w = vec_mem[base + 3 + K + row];
      first = (vec_mem[base + 2] != 8'h00) ? 0 : K - 1;
      acc_full = 0;
      acc_hi = 0;
      acc_lo = 0;
      for (int j = first; j < K; j++) begin
         d = vec_mem[base + 3 + j];
         acc_full = acc_full + sign_ext8(d) * sign_ext8(w);
         acc_hi = acc_hi + sign_ext4(d[7:4]) * sign_ext4(w[7:4]);
         acc_lo = acc_lo + sign_ext4(d[3:0]) * sign_ext4(w[3:0]);
      end
      r = '0;
      if (vec_mem[base] == 8'h01) begin
         r.lanes.hi = acc_hi[3:0];  // lanes wrap on their own
         r.lanes.lo = acc_lo[3:0];
      end else begin
         r.full = acc_full[7:0];
      end
      return r;
   endfunction

   function automatic string test_label(input int base);
      string s;
      s = (vec_mem[base] == 8'h01) ? "int4x2" : "int8";
      if (vec_mem[base + 1] == 8'h00) begin
         s = {s, " freeze"};
      end else if (vec_mem[base + 2] == 8'h00) begin
         s = {s, " chain cut"};
      end else begin
         s = {s, " chain"};
      end
      return s;
   endfunction

   // ==============================
   // stimulus and checks
   // ==============================
   task automatic check_word(input mxu_prec_pkg::mxu_word_u exp_word,
                             input mxu_prec_pkg::mxu_word_u act_word,
                             input int row, input string what);
      if (act_word !== exp_word) begin
         $display("Mismatch at %t: %s, row %0d expected %h actual %h",
                  $time, what, row, exp_word, act_word);
         test_errors++;
         n_errors++;
      end
   endtask

   task automatic wait_cycles(input int n);
      int count;
      count = 0;
      while (count < n) begin
         @(posedge clk);
         count++;
      end
   endtask

   task automatic wait_reset_release(output bit released);
      int cycles;
      cycles = 0;
      while (rst_n !== 1'b1 && cycles < RST_TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      released = (rst_n === 1'b1);
   endtask

   task automatic drive_vector(input int base);
      logic [K*W-1:0] d_vec;
      logic [M*W-1:0] w_vec;
      for (int j = 0; j < K; j++) begin
         d_vec[j*W +: W] = vec_mem[base + 3 + j];
      end
      for (int i = 0; i < M; i++) begin
         w_vec[i*W +: W] = vec_mem[base + 3 + K + i];
      end
      @(posedge clk);
      data_type    <= vec_mem[base][1:0];
      enable       <= vec_mem[base + 1][0];
      enable_chain <= vec_mem[base + 2][0];
      input_data   <= d_vec;
      weight       <= w_vec;
   endtask

   // one in-flight vector that the next one replaces a cycle later
   task automatic drive_random();
      int unsigned rnd;
      logic [K*W-1:0] d_vec;
      logic [M*W-1:0] w_vec;
      for (int j = 0; j < K; j++) begin
         rnd = $urandom();
         d_vec[j*W +: W] = rnd[W-1:0];
      end
      for (int i = 0; i < M; i++) begin
         rnd = $urandom();
         w_vec[i*W +: W] = rnd[W-1:0];
      end
      rnd = $urandom();
      @(posedge clk);
      data_type    <= {1'b0, rnd[0]};  // legal codes only
      enable       <= 1'b1;
      enable_chain <= rnd[1];
      input_data   <= d_vec;
      weight       <= w_vec;
   endtask

   task automatic finish_test(input int num, input string label);
      n_tests++;
      if (test_errors == 0) begin
         $display("test %0d %s: ok", num, label);
      end else begin
         n_failed++;
         $display("test %0d %s: %0d errors", num, label, test_errors);
      end
   endtask

   task automatic run_vector(input int num, input int base);
      int hold;
      int burst;
      logic en;
      mxu_prec_pkg::mxu_word_u exp_row;
      mxu_prec_pkg::mxu_word_u file_row;
      test_errors = 0;
      if (vec_mem[base] > 8'h01 || vec_mem[base + 1] > 8'h01 || vec_mem[base + 2] > 8'h01) begin
         $display("Data file error: test %0d has a control field out of range", num);
         test_errors++;
         n_errors++;
      end else begin
         en = vec_mem[base + 1][0];
         hold = M + K + 2 + int'($urandom_range(3));  // above the M+K settle time
         for (int i = 0; i < M; i++) begin
            if (en) begin
               exp_row = model_row(base, i);
            end else begin
               exp_row = last_exp[i];  // frozen y keeps the last result
            end
            file_row = vec_mem[base + 3 + K + M + i];
            if (file_row !== exp_row) begin
               $display("Data file error: test %0d row %0d lists %h, lane rules give %h",
                        num, i, file_row, exp_row);
               test_errors++;
               n_errors++;
            end
            next_exp[i] = exp_row;
         end
         if (en) begin
            burst = 1 + int'($urandom_range(3));
            for (int b = 0; b < burst; b++) begin
               drive_random();
            end
            drive_vector(base);
            wait_cycles(hold);
            @(negedge clk);
            for (int i = 0; i < M; i++) begin
               check_word(next_exp[i], y[i*W +: W], i, "settled result");
               last_exp[i] = next_exp[i];
            end
         end else begin
            drive_vector(base);
            for (int c = 0; c < hold; c++) begin
               @(negedge clk);
               for (int i = 0; i < M; i++) begin
                  check_word(next_exp[i], y[i*W +: W], i, "frozen output");
               end
            end
         end
      end
      finish_test(num, test_label(base));
   endtask

   // ==============================
   // main sequence
   // ==============================
   initial begin
      int t;
      int base;
      bit done;
      bit released;
      $timeformat(-9, 0, " ns", 0);
      void'($urandom(75));
      data_type    <= 2'b00;
      enable       <= 1'b1;  // reset has to win over an enabled array
      enable_chain <= 1'b1;
      input_data   <= {K{8'h5a}};
      weight       <= {M{8'h3c}};
      n_tests = 0;
      n_failed = 0;
      n_errors = 0;
      $readmemh(TESTDATA, vec_mem);

      @(posedge clk);
      enable <= 1'b0;  // still in reset here

      wait_reset_release(released);
      if (!released) begin
         $display("Timeout: reset was not released within %0d cycles", RST_TIMEOUT);
         n_failed++;
      end else begin
         @(negedge clk);
         test_errors = 0;
         for (int i = 0; i < M; i++) begin
            check_word('0, y[i*W +: W], i, "after reset");
            last_exp[i] = '0;
         end
         finish_test(0, "reset");

         t = 0;
         done = 1'b0;
         while (!done && t < MAX_TESTS) begin
            base = t * VEC_W;
            if ($isunknown(vec_mem[base]) || vec_mem[base] == 8'hff) begin
               done = 1'b1;  // end marker
            end else begin
               run_vector(t + 1, base);
               t++;
            end
         end

         if (n_tests < 2) begin
            $display("Error: no test vectors were read from %s", TESTDATA);
            n_failed++;
         end
      end

      $display("summary: %0d tests, %0d failed, %0d errors", n_tests, n_failed, n_errors);
      if (n_failed == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* tb/mxu_testdata.txt */
// mode en chain | d0 d1 d2 | w0 w1 w2 | y0 y1 y2 (hex, mode 00 int8, 01 int4x2)
// a line with en 00 freezes the array and its y columns are the held values
// int8 with the chain
00 01 01  01 02 03  01 02 03  06 0c 12
00 01 01  10 20 30  02 03 04  c0 20 80
00 01 01  ff fe fd  05 fb 7f  e2 1e 06
00 01 01  7f 7f 7f  7f 80 03  03 80 77
00 01 01  12 34 56  00 01 ff  00 9c 64
// int4x2 with the chain
01 01 01  12 34 56  11 21 32  9c 2c b8
01 01 01  1f 2f 3e  13 f5 27  64 ac c4
01 01 01  88 77 99  8f 7f 11  08 88 88
01 01 01  f1 e2 d3  22 ef 09  4c ca 06
// chain cut
00 01 00  05 06 07  02 03 ff  0e 15 f9
01 01 00  11 22 3d  12 f3 44  3a d7 c4
00 01 00  40 50 80  01 02 03  80 00 80
// freeze after a settled result, then release
00 01 01  01 01 01  03 04 05  09 0c 0f
01 00 00  aa bb cc  55 66 77  09 0c 0f
01 01 00  aa bb cc  55 66 77  cc 88 44
00 00 01  01 02 03  04 05 06  cc 88 44
00 01 01  01 02 03  04 05 06  18 1e 24
// mixed
01 01 01  7f 80 01  7f 81 ff  90 80 10
00 01 01  80 80 80  ff 01 02  80 80 00
00 01 00  00 00 00  12 34 56  00 00 00
00 01 01  03 05 07  02 fe 10  1e e2 f0
00 00 00  99 88 77  11 22 33  1e e2 f0
00 01 00  99 88 77  11 22 33  e7 ce b5
// end marker
ff

/* mxu_array.f */
rtl/mxu_prec_pkg.sv
rtl/mxu_geom_pkg.sv
rtl/mxu_mult.sv
rtl/mxu_mac.sv
rtl/mxu_core.sv
rtl/mxu_top.sv
tb/mxu_clk_gen.sv
tb/mxu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the mxu testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=mxu_tb
BUILD_DIR=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
   echo "verilator not found in PATH"
   exit 1
fi

verilator --binary --timing --assert -j 0 --top-module "$TOP" -Mdir "$BUILD_DIR" -f mxu_array.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

output=$("./$BUILD_DIR/V$TOP" 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "TESTBENCH PASSED"; then
   echo "simulation result: pass"
   exit 0
fi
echo "simulation result: fail"
exit 1
